// File: flist.f
+incdir+src
src/side_ch_pkg.sv
src/side_ch_counter_event_cfg.sv
src/side_ch_event_counters.sv
src/side_ch_cfg_regs.sv
src/side_ch_counter_top.sv
dv/side_ch_clk_gen.sv
dv/side_ch_properties.sv
dv/side_ch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = side_ch_tb
FLIST = flist.f
OBJ_DIR = obj_dir
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/side_ch_tb.sv
// testbench with traffic generator, reference counter model, read checks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_tb;

	import side_ch_pkg::*;

	localparam int DW = `SIDE_CH_DATA_WIDTH;
	localparam int AW = `SIDE_CH_ADDR_WIDTH;
	localparam int NE = `SIDE_CH_NUM_EVENT;
	localparam int RW = `SIDE_CH_RSSI_WIDTH;
	localparam int GW = `SIDE_CH_GPIO_WIDTH - 1;

	// stimulus lengths in cycles
	localparam int REG_CYCLES = 160;
	localparam int RX_CYCLES = 400;
	localparam int TX_CYCLES = 400;
	localparam int MIX_CYCLES = 300;
	localparam int CLR_CYCLES = 40;
	localparam int BURST_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = 2 * (REG_CYCLES + RX_CYCLES + TX_CYCLES + MIX_CYCLES
		+ CLR_CYCLES + BURST_CYCLES) + 200;

	localparam int MODE_IDLE = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_HIGH = 2;

	logic clk;
	logic rstn;
	rx_status_t rx_status;
	tx_status_t tx_status;
	logic reg_wr;
	logic reg_rd;
	logic [AW-1:0] reg_addr;
	logic [DW-1:0] reg_wdata;
	logic [DW-1:0] reg_rdata;

	int mode;
	int cycle_count = 0;
	logic [DW-1:0] target_val;
	logic signed [RW-1:0] th_val;

	// reference model state
	logic [NE-1:0] m_sel;
	logic signed [RW-1:0] m_th;
	logic [DW-1:0] m_target;
	logic [NE-1:0] m_clr;
	logic [GW-1:0] m_prev_gain;
	logic [DW-1:0] m_cnt [NE];
	logic [DW-1:0] exp_rdata;
	logic check_due;

	side_ch_clk_gen u_clk_gen (
		.clk  (clk),
		.rstn (rstn)
	);

	side_ch_counter_top dut (
		.clk       (clk),
		.rstn      (rstn),
		.rx_status (rx_status),
		.tx_status (tx_status),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata)
	);

	// select 0 and select 1 sources of each event for one cycle of status
	function automatic logic [NE-1:0] model_events(input rx_status_t rx, input tx_status_t tx);
		logic [NE-1:0] s0;
		logic [NE-1:0] s1;
		logic [NE-1:0] ev;
		logic match;
		logic fcs_hit;
		match = (rx.addr2[47:40] == m_target[7:0]) && (rx.addr2[39:32] == m_target[15:8])
			&& (rx.addr2[31:24] == m_target[23:16]) && (rx.addr2[23:16] == m_target[31:24]);
		fcs_hit = rx.fcs_in_strobe && match && rx.pkt_for_me && rx.is_data;
		s0 = {fcs_hit && rx.fcs_ok, fcs_hit, rx.pkt_header_valid_strobe && rx.pkt_header_valid,
			rx.pkt_header_valid_strobe, rx.long_preamble_detected, rx.short_preamble_detected};
		s1 = {tx.tx_pkt_need_ack, rx.agc.agc_lock, rx.agc.gain != m_prev_gain,
			$signed(rx.rssi_half_db) > m_th, tx.phy_tx_done, tx.phy_tx_start};
		for (int i = 0; i < NE; i++) ev[i] = m_sel[i] ? s1[i] : s0[i];
		return ev;
	endfunction

	// readback of the register map from the model state
	function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] addr);
		int idx;
		idx = int'(addr) - int'(`SIDE_CH_REG_COUNTER_BASE);
		if (addr == `SIDE_CH_REG_EVENT_SEL) return {{(DW-NE){1'b0}}, m_sel};
		if (addr == `SIDE_CH_REG_RSSI_TH) return {{(DW-RW){1'b0}}, m_th};
		if (addr == `SIDE_CH_REG_ADDR2_TARGET) return m_target;
		if (idx >= 0 && idx < NE) return m_cnt[idx];
		return '0;
	endfunction

	always @(posedge clk) begin : model_update
		logic [NE-1:0] ev;
		if (!rstn) begin
			m_sel = '0;
			m_th = '0;
			m_target = '0;
			m_clr = '0;
			m_prev_gain = '0;
			check_due = 1'b0;
			for (int i = 0; i < NE; i++) m_cnt[i] = '0;
		end else begin
			// reads see the state before this edge
			check_due = reg_rd;
			if (reg_rd) exp_rdata = expected_read(reg_addr);
			ev = model_events(rx_status, tx_status);
			for (int i = 0; i < NE; i++) begin
				if (m_clr[i]) m_cnt[i] = '0;
				else if (ev[i]) m_cnt[i] = m_cnt[i] + 32'd1;
			end
			m_prev_gain = rx_status.agc.gain;
			m_clr = '0;
			if (reg_wr) begin
				case (reg_addr)
					`SIDE_CH_REG_EVENT_SEL: m_sel = reg_wdata[NE-1:0];
					`SIDE_CH_REG_RSSI_TH: m_th = reg_wdata[RW-1:0];
					`SIDE_CH_REG_ADDR2_TARGET: m_target = reg_wdata;
					`SIDE_CH_REG_COUNTER_CLR: m_clr = reg_wdata[NE-1:0];
					default: m_clr = '0;
				endcase
			end
		end
	end

	always @(negedge clk) begin
		if (check_due) begin
			assert (reg_rdata == exp_rdata) else begin
				$display("FAIL t=%0t reg_rdata got %08h expected %08h", $time, reg_rdata, exp_rdata);
				$display("Test failed");
				$fatal(1, "read data mismatch");
			end
		end
		if (dut.u_props.violation) begin
			$display("a register port assertion on the DUT fired");
			$display("Test failed");
			$fatal(1, "register port assertion");
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout reached after %0d cycles", cycle_count);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	task automatic drive_random_status();
		rx_status.short_preamble_detected = 1'($urandom);
		rx_status.long_preamble_detected = 1'($urandom);
		rx_status.pkt_header_valid_strobe = 1'($urandom);
		rx_status.pkt_header_valid = 1'($urandom);
		rx_status.fcs_in_strobe = 1'($urandom);
		rx_status.fcs_ok = 1'($urandom);
		rx_status.pkt_for_me = 1'($urandom);
		rx_status.is_data = 1'($urandom);
		rx_status.addr2 = {16'($urandom), 32'($urandom)};
		// about half the frames come from the watched transmitter
		if (1'($urandom)) begin
			rx_status.addr2[47:16] = {target_val[7:0], target_val[15:8],
				target_val[23:16], target_val[31:24]};
		end
		rx_status.rssi_half_db = th_val + RW'($urandom % 9) - RW'(4);
		if (1'($urandom)) rx_status.agc.gain = GW'($urandom);
		rx_status.agc.agc_lock = 1'($urandom);
		tx_status = tx_status_t'(3'($urandom));
	endtask

	// every select 1 source high in every cycle
	task automatic drive_high_status();
		rx_status.rssi_half_db = {1'b0, {(RW-1){1'b1}}};
		rx_status.agc.gain = rx_status.agc.gain + GW'(1);
		rx_status.agc.agc_lock = 1'b1;
		tx_status = '1;
	endtask

	initial begin : traffic
		rx_status = '0;
		tx_status = '0;
		forever begin
			@(negedge clk);
			if (mode == MODE_RANDOM) begin
				drive_random_status();
			end else if (mode == MODE_HIGH) begin
				drive_high_status();
			end else begin
				rx_status = '0;
				tx_status = '0;
			end
		end
	end

	task automatic reg_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
		@(negedge clk);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input logic [AW-1:0] addr);
		@(negedge clk);
		reg_rd = 1'b1;
		reg_addr = addr;
		@(negedge clk);
		reg_rd = 1'b0;
	endtask

	task automatic read_counters();
		for (int i = 0; i < NE; i++) reg_read(AW'(int'(`SIDE_CH_REG_COUNTER_BASE) + i));
	endtask

	// one read strobe per cycle over all counters
	task automatic read_counter_burst();
		for (int i = 0; i < NE; i++) begin
			@(negedge clk);
			reg_rd = 1'b1;
			reg_addr = AW'(int'(`SIDE_CH_REG_COUNTER_BASE) + i);
		end
		@(negedge clk);
		reg_rd = 1'b0;
	endtask

	initial begin
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		mode = MODE_IDLE;
		target_val = '0;
		th_val = '0;
		void'($urandom(32'h1ff5_ae4c));
		@(posedge rstn);

		// reset values everywhere before the configuration readback
		for (int a = 0; a < (1 << AW); a++) reg_read(AW'(a));
		reg_write(`SIDE_CH_REG_EVENT_SEL, $urandom);
		reg_write(`SIDE_CH_REG_RSSI_TH, $urandom);
		reg_write(`SIDE_CH_REG_ADDR2_TARGET, $urandom);
		reg_read(`SIDE_CH_REG_EVENT_SEL);
		reg_read(`SIDE_CH_REG_RSSI_TH);
		reg_read(`SIDE_CH_REG_ADDR2_TARGET);

		// receiver traffic on the select 0 sources
		target_val = $urandom;
		th_val = -11'sd37;
		reg_write(`SIDE_CH_REG_EVENT_SEL, '0);
		reg_write(`SIDE_CH_REG_RSSI_TH, {{(DW-RW){1'b0}}, th_val});
		reg_write(`SIDE_CH_REG_ADDR2_TARGET, target_val);
		mode = MODE_RANDOM;
		repeat (RX_CYCLES) @(negedge clk);
		mode = MODE_IDLE;
		read_counters();

		// tx, rssi and agc traffic on the select 1 sources
		reg_write(`SIDE_CH_REG_EVENT_SEL, 32'h3f);
		mode = MODE_RANDOM;
		repeat (TX_CYCLES) @(negedge clk);
		mode = MODE_IDLE;
		read_counters();

		// select pattern changed under running traffic
		mode = MODE_RANDOM;
		repeat (MIX_CYCLES / 2) @(negedge clk);
		reg_write(`SIDE_CH_REG_EVENT_SEL, 32'h25);
		repeat (MIX_CYCLES / 2) @(negedge clk);
		read_counters();
		mode = MODE_IDLE;

		// partial clear while all events stay high
		reg_write(`SIDE_CH_REG_EVENT_SEL, 32'h3f);
		mode = MODE_HIGH;
		repeat (CLR_CYCLES / 2) @(negedge clk);
		reg_write(`SIDE_CH_REG_COUNTER_CLR, 32'h16);
		repeat (CLR_CYCLES / 2) @(negedge clk);
		read_counters();
		reg_read(`SIDE_CH_REG_COUNTER_CLR);

		// unmapped addresses stay zero with live counters and configuration
		for (int a = int'(`SIDE_CH_REG_COUNTER_BASE) + NE; a < (1 << AW); a++) begin
			reg_read(AW'(a));
		end

		read_counter_burst();
		mode = MODE_IDLE;
		@(negedge clk);

		if (dut.u_props.violation) begin
			$display("a register port assertion on the DUT fired");
			$display("Test failed");
			$fatal(1, "register port assertion");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: dv/side_ch_properties.sv
// concurrent assertions on the register port of the counter top level, with bind
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_properties (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           reg_wr,
	input  logic                           reg_rd,
	input  logic [`SIDE_CH_ADDR_WIDTH-1:0] reg_addr,
	input  logic [`SIDE_CH_DATA_WIDTH-1:0] reg_rdata
);

	logic reset_bad = 1'b0;
	logic unknown_bad = 1'b0;
	logic change_bad = 1'b0;
	logic collide_bad = 1'b0;
	logic clr_read_bad = 1'b0;

	// sticky summary, sampled by the testbench
	logic violation;
	assign violation = reset_bad | unknown_bad | change_bad | collide_bad | clr_read_bad;

	a_rdata_reset: assert property (@(posedge clk) $rose(rstn) |-> reg_rdata == '0)
		else begin
			$error("reg_rdata not zero when reset is released");
			reset_bad = 1'b1;
		end

	a_rdata_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(reg_rdata))
		else begin
			$error("reg_rdata has unknown bits");
			unknown_bad = 1'b1;
		end

	// read data only moves at the edge that samples a read strobe
	a_rdata_hold: assert property (@(posedge clk) disable iff (!rstn)
		!$stable(reg_rdata) |-> $past(reg_rd))
		else begin
			$error("reg_rdata changed without a read strobe");
			change_bad = 1'b1;
		end

	a_no_collide: assert property (@(posedge clk) disable iff (!rstn) !(reg_wr && reg_rd))
		else begin
			$error("reg_wr and reg_rd high together");
			collide_bad = 1'b1;
		end

	a_clr_reads_zero: assert property (@(posedge clk) disable iff (!rstn)
		(reg_rd && reg_addr == `SIDE_CH_REG_COUNTER_CLR) |=> reg_rdata == '0)
		else begin
			$error("read of the counter clear address returned nonzero");
			clr_read_bad = 1'b1;
		end

endmodule

bind side_ch_counter_top side_ch_properties u_props (
	.clk       (clk),
	.rstn      (rstn),
	.reg_wr    (reg_wr),
	.reg_rd    (reg_rd),
	.reg_addr  (reg_addr),
	.reg_rdata (reg_rdata)
);

`default_nettype wire

// File: dv/side_ch_clk_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module side_ch_clk_gen (
	output logic clk,
	output logic rstn
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held low over five rising edges, released on a falling edge
	initial begin
		rstn = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

// File: src/side_ch_counter_top.sv
// side channel event counter top level with register port
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_counter_top (
	input  logic                           clk,
	input  logic                           rstn,
	input  side_ch_pkg::rx_status_t        rx_status,
	input  side_ch_pkg::tx_status_t        tx_status,
	input  logic                           reg_wr,
	input  logic                           reg_rd,
	input  logic [`SIDE_CH_ADDR_WIDTH-1:0] reg_addr,
	input  logic [`SIDE_CH_DATA_WIDTH-1:0] reg_wdata,
	output logic [`SIDE_CH_DATA_WIDTH-1:0] reg_rdata
);

	import side_ch_pkg::*;

	event_cfg_t cfg;
	event_vec_t events;
	logic [`SIDE_CH_NUM_EVENT-1:0] clr;
	logic [`SIDE_CH_NUM_EVENT-1:0][`SIDE_CH_DATA_WIDTH-1:0] counts;

	side_ch_cfg_regs u_cfg_regs (
		.clk       (clk),
		.rstn      (rstn),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.counts    (counts),
		.cfg       (cfg),
		.clr       (clr)
	);

	// events are combinational from the status bundle
	side_ch_counter_event_cfg u_event_cfg (
		.clk       (clk),
		.rstn      (rstn),
		.rx_status (rx_status),
		.tx_status (tx_status),
		.cfg       (cfg),
		.events    (events)
	);

	side_ch_event_counters u_counters (
		.clk    (clk),
		.rstn   (rstn),
		.events (events),
		.clr    (clr),
		.counts (counts)
	);

endmodule

`default_nettype wire

// File: src/side_ch_cfg_regs.sv
// configuration registers, counter clear pulse and registered readback
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_cfg_regs (
	input  logic                                                clk,
	input  logic                                                rstn,
	input  logic                                                reg_wr,
	input  logic                                                reg_rd,
	input  logic [`SIDE_CH_ADDR_WIDTH-1:0]                      reg_addr,
	input  logic [`SIDE_CH_DATA_WIDTH-1:0]                      reg_wdata,
	output logic [`SIDE_CH_DATA_WIDTH-1:0]                      reg_rdata,
	input  logic [`SIDE_CH_NUM_EVENT-1:0][`SIDE_CH_DATA_WIDTH-1:0] counts,
	output side_ch_pkg::event_cfg_t                             cfg,
	output logic [`SIDE_CH_NUM_EVENT-1:0]                       clr
);

	localparam int unsigned DW = `SIDE_CH_DATA_WIDTH;
	localparam int unsigned RW = `SIDE_CH_RSSI_WIDTH;
	localparam int unsigned NE = `SIDE_CH_NUM_EVENT;

	// value presented to the read register
	logic [DW-1:0] rd_value;

	// write decode, clr only lives for the cycle after its write
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cfg.event_sel <= '0;
			cfg.rssi_half_db_th <= '0;
			cfg.addr2_target <= '0;
			clr <= '0;
		end else begin
			clr <= '0;
			if (reg_wr) begin
				case (reg_addr)
					`SIDE_CH_REG_EVENT_SEL: begin
						cfg.event_sel <= reg_wdata[NE-1:0];
					end
					`SIDE_CH_REG_RSSI_TH: begin
						cfg.rssi_half_db_th <= $signed(reg_wdata[RW-1:0]);
					end
					`SIDE_CH_REG_ADDR2_TARGET: begin
						cfg.addr2_target <= reg_wdata;
					end
					`SIDE_CH_REG_COUNTER_CLR: begin
						clr <= reg_wdata[NE-1:0];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// readback mux, unused bits and unmapped addresses give zero
	always_comb begin
		rd_value = '0;
		case (reg_addr)
			`SIDE_CH_REG_EVENT_SEL: begin
				rd_value = {{(DW-NE){1'b0}}, cfg.event_sel};
			end
			`SIDE_CH_REG_RSSI_TH: begin
				// stored bits only, no sign extension
				rd_value = {{(DW-RW){1'b0}}, cfg.rssi_half_db_th};
			end
			`SIDE_CH_REG_ADDR2_TARGET: begin
				rd_value = cfg.addr2_target;
			end
			default: begin
				for (int i = 0; i < NE; i++) begin
					if (reg_addr == `SIDE_CH_REG_COUNTER_BASE + `SIDE_CH_ADDR_WIDTH'(i)) begin
						rd_value = counts[i];
					end
				end
			end
		endcase
	end

	// held until the next read strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			reg_rdata <= '0;
		end else if (reg_rd) begin
			reg_rdata <= rd_value;
		end
	end

endmodule

`default_nettype wire

// File: src/side_ch_event_counters.sv
// wrapping per-event cycle counters with individual clear
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_event_counters (
	input  logic                                                clk,
	input  logic                                                rstn,
	input  side_ch_pkg::event_vec_t                             events,
	input  logic [`SIDE_CH_NUM_EVENT-1:0]                       clr,
	output logic [`SIDE_CH_NUM_EVENT-1:0][`SIDE_CH_DATA_WIDTH-1:0] counts
);

	genvar i;

	generate
		for (i = 0; i < `SIDE_CH_NUM_EVENT; i++) begin : g_cnt
			logic [`SIDE_CH_DATA_WIDTH-1:0] cnt_q;

			// clear beats a simultaneous increment
			always_ff @(posedge clk) begin
				if (!rstn) begin
					cnt_q <= '0;
				end else if (clr[i]) begin
					cnt_q <= '0;
				end else if (events[i]) begin
					// wraps naturally at 2^32
					cnt_q <= cnt_q + `SIDE_CH_DATA_WIDTH'(1);
				end
			end

			assign counts[i] = cnt_q;
		end
	endgenerate

endmodule

`default_nettype wire

// File: src/side_ch_counter_event_cfg.sv
// event strobe derivation with per-event source select for the side channel counters
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_settings.svh"

module side_ch_counter_event_cfg (
	input  logic                    clk,
	input  logic                    rstn,
	input  side_ch_pkg::rx_status_t rx_status,
	input  side_ch_pkg::tx_status_t tx_status,
	input  side_ch_pkg::event_cfg_t cfg,
	output side_ch_pkg::event_vec_t events
);

	import side_ch_pkg::*;

	// gain seen in the previous cycle
	logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_q;

	logic agc_lock;
	logic gain_change;
	logic rssi_above_th;
	logic addr2_match;
	logic hdr_ok;
	logic fcs_match;
	logic fcs_match_ok;

	// candidate sources, select 0 and select 1
	event_vec_t src0;
	event_vec_t src1;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gain_q <= '0;
		end else begin
			gain_q <= rx_status.agc.gain;
		end
	end

	assign agc_lock = rx_status.agc.agc_lock;
	assign gain_change = (rx_status.agc.gain != gain_q);

	// strictly greater, both operands signed
	assign rssi_above_th = (rx_status.rssi_half_db > cfg.rssi_half_db_th);

	// target low byte against addr2 byte 5, high byte against byte 2
	assign addr2_match = ({rx_status.addr2[23:16], rx_status.addr2[31:24],
		rx_status.addr2[39:32], rx_status.addr2[47:40]} == cfg.addr2_target);

	assign hdr_ok = rx_status.pkt_header_valid_strobe & rx_status.pkt_header_valid;

	// fcs strobe of a data frame for us from the watched transmitter
	assign fcs_match = rx_status.fcs_in_strobe & addr2_match
		& rx_status.pkt_for_me & rx_status.is_data;
	assign fcs_match_ok = fcs_match & rx_status.fcs_ok;

	assign src0 = {
		fcs_match_ok,
		fcs_match,
		hdr_ok,
		rx_status.pkt_header_valid_strobe,
		rx_status.long_preamble_detected,
		rx_status.short_preamble_detected
	};

	assign src1 = {
		tx_status.tx_pkt_need_ack,
		agc_lock,
		gain_change,
		rssi_above_th,
		tx_status.phy_tx_done,
		tx_status.phy_tx_start
	};

	// per-bit mux, sel bit high picks the second source
	assign events = (src1 & cfg.event_sel) | (src0 & ~cfg.event_sel);

endmodule

`default_nettype wire

// File: src/side_ch_pkg.sv
// status, configuration and event vector types for the side channel counters
`default_nettype none

`include "side_ch_settings.svh"

package side_ch_pkg;

	// agc status word as seen on the gpio bus
	typedef struct packed {
		logic agc_lock;
		logic [`SIDE_CH_GPIO_WIDTH-2:0] gain;
	} agc_status_t;

	// receiver flags, strobes and values
	typedef struct packed {
		logic short_preamble_detected;
		logic long_preamble_detected;
		logic pkt_header_valid_strobe;
		logic pkt_header_valid;
		logic fcs_in_strobe;
		logic fcs_ok;
		logic pkt_for_me;
		logic is_data;
		logic [47:0] addr2;
		logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db;
		agc_status_t agc;
	} rx_status_t;

	// transmitter strobes
	typedef struct packed {
		logic phy_tx_start;
		logic phy_tx_done;
		logic tx_pkt_need_ack;
	} tx_status_t;

	// software controlled event configuration
	typedef struct packed {
		logic [`SIDE_CH_NUM_EVENT-1:0] event_sel;
		logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db_th;
		logic [`SIDE_CH_DATA_WIDTH-1:0] addr2_target;
	} event_cfg_t;

	// bit i drives counter i
	typedef logic [`SIDE_CH_NUM_EVENT-1:0] event_vec_t;

endpackage

`default_nettype wire

// File: src/side_ch_settings.svh
// width, register map and counter count macros for the side channel counters
`ifndef SIDE_CH_SETTINGS_SVH
`define SIDE_CH_SETTINGS_SVH

// signed rssi in half-dB steps
`define SIDE_CH_RSSI_WIDTH 11
// agc status word, lock flag on top of the gain
`define SIDE_CH_GPIO_WIDTH 8
// register data width, also the counter width
`define SIDE_CH_DATA_WIDTH 32
// events and counters, one counter per event
`define SIDE_CH_NUM_EVENT 6
`define SIDE_CH_ADDR_WIDTH 4

// register map, sized to SIDE_CH_ADDR_WIDTH
`define SIDE_CH_REG_EVENT_SEL 4'd0
`define SIDE_CH_REG_RSSI_TH 4'd1
`define SIDE_CH_REG_ADDR2_TARGET 4'd2
`define SIDE_CH_REG_COUNTER_CLR 4'd3
// counters occupy BASE up to BASE + SIDE_CH_NUM_EVENT - 1
`define SIDE_CH_REG_COUNTER_BASE 4'd4

`endif
